// File: src/dmaDatapath_params.svh
`ifndef DMA_DATAPATH_PARAMS_SVH
`define DMA_DATAPATH_PARAMS_SVH

// number of dma channels
`define DMA_CHANNELS 4

// register target codes carried from decode to execute
// address register pair of a channel
`define REG_SEL_ADDR 3'd0
// word count register pair of a channel
`define REG_SEL_COUNT 3'd1
// command write or status read
`define REG_SEL_CMD 3'd2
// mode register write
`define REG_SEL_MODE 3'd3
// byte pointer clear
`define REG_SEL_CLRFF 3'd4
// unmapped address
`define REG_SEL_NONE 3'd7

// mode register bit positions
// address decrement select
`define MODE_DEC_BIT 5
// auto-initialize enable
`define MODE_AUTO_BIT 4

`endif

// File: src/dmaPkg.sv
`default_nettype none

package dmaPkg;

  // data bus byte
  typedef logic [7:0] dmaByte;

  // address or word count
  typedef logic [15:0] dmaWord;

  // channel number
  typedef logic [1:0] dmaChan;

  // register target code
  typedef logic [2:0] regSel;

  // command from decode to execute and result
  typedef struct packed {
    // one cycle write pulse
    logic   wrStrobe;
    // one cycle pulse once a read ends
    logic   rdDone;
    // addressed register
    regSel  target;
    // addressed channel
    dmaChan channel;
    // byte taken from the bus on a write
    dmaByte data;
  } busCmd;

  // current registers of the addressed channel
  typedef struct packed {
    dmaWord curAddress;
    dmaWord curCount;
    // high byte selected when set
    logic   bytePtr;
  } regView;

endpackage

`default_nettype wire

// File: src/dmaBusDecode.sv
`timescale 1ns/100ps
`default_nettype none

`include "dmaDatapath_params.svh"

module dmaBusDecode (
  input  wire logic           cpuIf,
  input  wire logic           rst,
  input  wire logic           csN,
  input  wire logic           iorN,
  input  wire logic           iowN,
  input  wire logic [3:0]     addr,
  input  wire dmaPkg::dmaByte dataIn,
  output dmaPkg::busCmd       cmd,
  output logic                readSel
);

  // registered bus pins
  logic           csNQ;
  logic           iorNQ;
  logic           iowNQ;
  logic [3:0]     addrQ;
  dmaPkg::dmaByte dataQ;

  // access levels and their delayed copies for edge detection
  logic wrAct;
  logic rdAct;
  logic wrActD;
  logic rdActD;

  // decoded target for the sampled address
  dmaPkg::regSel  targetNext;
  dmaPkg::dmaChan channelNext;

  // strobes idle high after reset
  always_ff @(posedge cpuIf)
  begin
    if (rst)
    begin
      csNQ  <= 1'b1;
      iorNQ <= 1'b1;
      iowNQ <= 1'b1;
    end
    else
    begin
      csNQ  <= csN;
      iorNQ <= iorN;
      iowNQ <= iowN;
    end
  end

  // address and data just follow the pins
  always_ff @(posedge cpuIf)
  begin
    addrQ <= addr;
    dataQ <= dataIn;
  end

  assign wrAct = !csNQ && !iowNQ;
  assign rdAct = !csNQ && !iorNQ;

  // address map
  always_comb
  begin
    channelNext = addrQ[2:1];
    if (!addrQ[3])
    begin
      // A0 picks address or word count of channel A2:A1
      targetNext = addrQ[0] ? `REG_SEL_COUNT : `REG_SEL_ADDR;
    end
    else
    begin
      case (addrQ[2:0])
        3'b000:  targetNext = `REG_SEL_CMD;
        3'b011:
        begin
          targetNext = `REG_SEL_MODE;
          // mode channel comes from the data byte
          channelNext = dataQ[1:0];
        end
        3'b100:  targetNext = `REG_SEL_CLRFF;
        default: targetNext = `REG_SEL_NONE;
      endcase
    end
  end

  always_ff @(posedge cpuIf)
  begin
    if (rst)
    begin
      wrActD      <= 1'b0;
      rdActD      <= 1'b0;
      readSel     <= 1'b0;
      cmd         <= '{wrStrobe: 1'b0, rdDone: 1'b0, target: `REG_SEL_NONE,
                       channel: '0, data: '0};
    end
    else
    begin
      wrActD <= wrAct;
      rdActD <= rdAct;
      // write fires on the falling edge of iowN
      cmd.wrStrobe <= wrAct && !wrActD;
      // read completes on the rising edge of iorN
      cmd.rdDone   <= !rdAct && rdActD;
      readSel      <= rdAct;
      // hold target and channel after the access so rdDone still sees them
      if (wrAct || rdAct)
      begin
        cmd.target  <= targetNext;
        cmd.channel <= channelNext;
        cmd.data    <= dataQ;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/dmaChannelRegs.sv
`timescale 1ns/100ps
`default_nettype none

`include "dmaDatapath_params.svh"

module dmaChannelRegs (
  input  wire logic                     cpuIf,
  input  wire logic                     rst,
  input  wire dmaPkg::busCmd            cmd,
  input  wire logic                     xferStep,
  input  wire dmaPkg::dmaChan           xferChannel,
  output dmaPkg::regView                view,
  output dmaPkg::dmaWord                xferAddress,
  output dmaPkg::dmaByte                xferMode,
  output dmaPkg::dmaByte                commandReg,
  output logic [`DMA_CHANNELS-1:0]      tcSet
);

  // per channel register file
  dmaPkg::dmaWord baseAddr  [`DMA_CHANNELS];
  dmaPkg::dmaWord curAddr   [`DMA_CHANNELS];
  dmaPkg::dmaWord baseCount [`DMA_CHANNELS];
  dmaPkg::dmaWord curCount  [`DMA_CHANNELS];
  dmaPkg::dmaByte modeReg   [`DMA_CHANNELS];

  // low or high byte select
  logic bytePtr;

  // decoded cpu accesses
  logic addrWrite;
  logic countWrite;
  logic pairAccess;

  // stepping channel next values
  dmaPkg::dmaByte stepMode;
  dmaPkg::dmaWord stepAddr;
  dmaPkg::dmaWord stepCount;
  logic           termCount;

  // replace one byte of a word
  function automatic dmaPkg::dmaWord putByte(input dmaPkg::dmaWord word,
                                             input dmaPkg::dmaByte value,
                                             input logic           high);
    dmaPkg::dmaWord result;
    result = word;
    if (high)
      result[15:8] = value;
    else
      result[7:0] = value;
    return result;
  endfunction

  assign addrWrite  = cmd.wrStrobe && cmd.target == `REG_SEL_ADDR;
  assign countWrite = cmd.wrStrobe && cmd.target == `REG_SEL_COUNT;
  // reads and writes of either pair move the pointer
  assign pairAccess = (cmd.wrStrobe || cmd.rdDone) &&
                      (cmd.target == `REG_SEL_ADDR || cmd.target == `REG_SEL_COUNT);

  // next address and count of the stepping channel
  always_comb
  begin
    stepMode  = modeReg[xferChannel];
    stepAddr  = stepMode[`MODE_DEC_BIT] ? curAddr[xferChannel] - 16'd1
                                        : curAddr[xferChannel] + 16'd1;
    stepCount = curCount[xferChannel] - 16'd1;
    // count rolls from zero to FFFF
    termCount = xferStep && curCount[xferChannel] == '0;
  end

  always_ff @(posedge cpuIf)
  begin
    if (rst)
    begin
      for (int i = 0; i < `DMA_CHANNELS; i++)
      begin
        baseAddr[i]  <= '0;
        curAddr[i]   <= '0;
        baseCount[i] <= '0;
        curCount[i]  <= '0;
      end
    end
    else
    begin
      if (xferStep)
      begin
        if (termCount && stepMode[`MODE_AUTO_BIT])
        begin
          // auto-initialize reload
          curAddr[xferChannel]  <= baseAddr[xferChannel];
          curCount[xferChannel] <= baseCount[xferChannel];
        end
        else
        begin
          curAddr[xferChannel]  <= stepAddr;
          curCount[xferChannel] <= stepCount;
        end
      end
      // cpu write loads base and current together and wins over a step
      if (addrWrite)
      begin
        baseAddr[cmd.channel] <= putByte(baseAddr[cmd.channel], cmd.data, bytePtr);
        curAddr[cmd.channel]  <= putByte(curAddr[cmd.channel], cmd.data, bytePtr);
      end
      if (countWrite)
      begin
        baseCount[cmd.channel] <= putByte(baseCount[cmd.channel], cmd.data, bytePtr);
        curCount[cmd.channel]  <= putByte(curCount[cmd.channel], cmd.data, bytePtr);
      end
    end
  end

  // mode, command and byte pointer
  always_ff @(posedge cpuIf)
  begin
    if (rst)
    begin
      for (int i = 0; i < `DMA_CHANNELS; i++)
        modeReg[i] <= '0;
      commandReg <= '0;
      bytePtr    <= 1'b0;
    end
    else
    begin
      if (cmd.wrStrobe && cmd.target == `REG_SEL_MODE)
        modeReg[cmd.channel] <= cmd.data;
      if (cmd.wrStrobe && cmd.target == `REG_SEL_CMD)
        commandReg <= cmd.data;
      // clear write restarts at the low byte
      if (cmd.wrStrobe && cmd.target == `REG_SEL_CLRFF)
        bytePtr <= 1'b0;
      else if (pairAccess)
        bytePtr <= !bytePtr;
    end
  end

  // one cycle terminal count flag per channel
  always_ff @(posedge cpuIf)
  begin
    if (rst)
      tcSet <= '0;
    else
    begin
      tcSet <= '0;
      if (termCount)
        tcSet[xferChannel] <= 1'b1;
    end
  end

  // addressed channel for the read path
  assign view.curAddress = curAddr[cmd.channel];
  assign view.curCount   = curCount[cmd.channel];
  assign view.bytePtr    = bytePtr;

  // stepping channel outputs
  assign xferAddress = curAddr[xferChannel];
  assign xferMode    = modeReg[xferChannel];

endmodule

`default_nettype wire

// File: src/dmaReadPort.sv
`timescale 1ns/100ps
`default_nettype none

`include "dmaDatapath_params.svh"

module dmaReadPort (
  input  wire logic                     cpuIf,
  input  wire logic                     rst,
  input  wire dmaPkg::busCmd            cmd,
  input  wire logic                     readSel,
  input  wire dmaPkg::regView           view,
  input  wire logic [`DMA_CHANNELS-1:0] tcSet,
  output dmaPkg::dmaByte                dataOut,
  output logic                          dataOutEn,
  output logic                          tcPulse
);

  // terminal count bits of the status register
  logic [`DMA_CHANNELS-1:0] tcStatus;
  logic                     statusClear;
  dmaPkg::dmaByte           statusByte;
  dmaPkg::dmaByte           readByte;

  // status read clears once it completes
  assign statusClear = cmd.rdDone && cmd.target == `REG_SEL_CMD;

  always_ff @(posedge cpuIf)
  begin
    if (rst)
      tcStatus <= '0;
    else
      // a new terminal count beats the clear
      tcStatus <= (statusClear ? '0 : tcStatus) | tcSet;
  end

  // request bits in the upper nibble stay zero
  assign statusByte = {{(8 - `DMA_CHANNELS){1'b0}}, tcStatus};

  // byte for the addressed register
  always_comb
  begin
    case (cmd.target)
      `REG_SEL_ADDR:
        readByte = view.bytePtr ? view.curAddress[15:8] : view.curAddress[7:0];
      `REG_SEL_COUNT:
        readByte = view.bytePtr ? view.curCount[15:8] : view.curCount[7:0];
      `REG_SEL_CMD:
        readByte = statusByte;
      default:
        readByte = '0;
    endcase
  end

  // output enable follows the read level one edge later
  always_ff @(posedge cpuIf)
  begin
    if (rst)
      dataOutEn <= 1'b0;
    else
      dataOutEn <= readSel;
  end

  // bus idles at zero between reads
  always_ff @(posedge cpuIf)
  begin
    if (readSel)
      dataOut <= readByte;
    else
      dataOut <= '0;
  end

  // any channel reaching terminal count
  assign tcPulse = |tcSet;

endmodule

`default_nettype wire

// File: src/dmaDatapath.sv
`timescale 1ns/100ps
`default_nettype none

`include "dmaDatapath_params.svh"

module dmaDatapath (
  input  wire logic           cpuIf,
  input  wire logic           rst,
  input  wire logic           csN,
  input  wire logic           iorN,
  input  wire logic           iowN,
  input  wire logic [3:0]     addr,
  input  wire dmaPkg::dmaByte dataIn,
  output dmaPkg::dmaByte      dataOut,
  output logic                dataOutEn,
  input  wire logic           xferStep,
  input  wire dmaPkg::dmaChan xferChannel,
  output dmaPkg::dmaWord      xferAddress,
  output dmaPkg::dmaByte      xferMode,
  output dmaPkg::dmaByte      commandReg,
  output logic                tcPulse
);

  // decode to execute and result
  dmaPkg::busCmd  cmd;
  logic           readSel;

  // execute to result
  dmaPkg::regView view;
  logic [`DMA_CHANNELS-1:0] tcSet;

  dmaBusDecode decode (
    .cpuIf   (cpuIf),
    .rst     (rst),
    .csN     (csN),
    .iorN    (iorN),
    .iowN    (iowN),
    .addr    (addr),
    .dataIn  (dataIn),
    .cmd     (cmd),
    .readSel (readSel)
  );

  dmaChannelRegs execute (
    .cpuIf       (cpuIf),
    .rst         (rst),
    .cmd         (cmd),
    .xferStep    (xferStep),
    .xferChannel (xferChannel),
    .view        (view),
    .xferAddress (xferAddress),
    .xferMode    (xferMode),
    .commandReg  (commandReg),
    .tcSet       (tcSet)
  );

  dmaReadPort result (
    .cpuIf     (cpuIf),
    .rst       (rst),
    .cmd       (cmd),
    .readSel   (readSel),
    .view      (view),
    .tcSet     (tcSet),
    .dataOut   (dataOut),
    .dataOutEn (dataOutEn),
    .tcPulse   (tcPulse)
  );

endmodule

`default_nettype wire

// File: tb/dmaDatapathTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "dmaDatapath_params.svh"

module dmaDatapathTb;

  // well above the length of the full sequence
  localparam int cycleLimit = 4000;

  logic           cpuIf;
  logic           rst;
  logic           csN;
  logic           iorN;
  logic           iowN;
  logic [3:0]     addr;
  dmaPkg::dmaByte dataIn;
  dmaPkg::dmaByte dataOut;
  logic           dataOutEn;
  logic           xferStep;
  dmaPkg::dmaChan xferChannel;
  dmaPkg::dmaWord xferAddress;
  dmaPkg::dmaByte xferMode;
  dmaPkg::dmaByte commandReg;
  logic           tcPulse;

  // reference model state
  logic [15:0] refBaseAddr  [`DMA_CHANNELS];
  logic [15:0] refCurAddr   [`DMA_CHANNELS];
  logic [15:0] refBaseCount [`DMA_CHANNELS];
  logic [15:0] refCurCount  [`DMA_CHANNELS];
  logic [7:0]  refMode      [`DMA_CHANNELS];
  logic [7:0]  refCmd;
  logic        refPtr;
  logic [3:0]  refStatus;
  logic        expectTc;

  // values written by the stimulus
  logic [15:0] loadedAddr  [`DMA_CHANNELS];
  logic [15:0] loadedCount [`DMA_CHANNELS];
  logic [15:0] randWord;
  logic        sawTc;

  logic [7:0] lfsrState;
  int         checkCount;
  int         errorCount;
  int         cycleCount;

  dmaDatapath DUT (
    .cpuIf       (cpuIf),
    .rst         (rst),
    .csN         (csN),
    .iorN        (iorN),
    .iowN        (iowN),
    .addr        (addr),
    .dataIn      (dataIn),
    .dataOut     (dataOut),
    .dataOutEn   (dataOutEn),
    .xferStep    (xferStep),
    .xferChannel (xferChannel),
    .xferAddress (xferAddress),
    .xferMode    (xferMode),
    .commandReg  (commandReg),
    .tcPulse     (tcPulse)
  );

  initial
  begin
    cpuIf = 1'b0;
    forever #4 cpuIf = ~cpuIf;
  end

  // taps 8 6 5 4
  function automatic logic [7:0] lfsrNext(input logic [7:0] state);
    return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
  endfunction

  // one lfsr step per bit taken
  task automatic nextRandom(input int width, output logic [15:0] value);
    value = '0;
    for (int i = 0; i < width; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[14:0], lfsrState[0]};
    end
  endtask

  task automatic checkValue(input string name, input logic [15:0] got,
                            input logic [15:0] expected);
    checkCount++;
    assert (got === expected)
    else
    begin
      errorCount++;
      $display("mismatch %s: got %h expected %h at %0t", name, got, expected, $time);
    end
  endtask

  // expected read byte from the address map
  function automatic logic [7:0] refByte(input logic [3:0] a);
    logic [15:0] word;
    if (a[3])
      return (a == 4'b1000) ? {4'b0000, refStatus} : 8'h00;
    word = a[0] ? refCurCount[a[2:1]] : refCurAddr[a[2:1]];
    return refPtr ? word[15:8] : word[7:0];
  endfunction

  // address and count writes load base and current
  task automatic modelWrite(input logic [3:0] a, input logic [7:0] d);
    logic [1:0] ch;
    ch = a[2:1];
    if (!a[3] && !a[0])
    begin
      if (refPtr)
        refBaseAddr[ch][15:8] = d;
      else
        refBaseAddr[ch][7:0] = d;
      refCurAddr[ch] = refBaseAddr[ch];
      refPtr = !refPtr;
    end
    else if (!a[3])
    begin
      if (refPtr)
        refBaseCount[ch][15:8] = d;
      else
        refBaseCount[ch][7:0] = d;
      refCurCount[ch] = refBaseCount[ch];
      refPtr = !refPtr;
    end
    else if (a[2:0] == 3'b000)
      refCmd = d;
    else if (a[2:0] == 3'b011)
      refMode[d[1:0]] = d;
    else if (a[2:0] == 3'b100)
      refPtr = 1'b0;
  endtask

  task automatic modelStep(input logic [1:0] ch);
    logic tc;
    tc = refCurCount[ch] == 16'h0000;
    expectTc = tc;
    if (tc)
      refStatus[ch] = 1'b1;
    if (tc && refMode[ch][`MODE_AUTO_BIT])
    begin
      refCurAddr[ch]  = refBaseAddr[ch];
      refCurCount[ch] = refBaseCount[ch];
    end
    else
    begin
      refCurAddr[ch]  = refMode[ch][`MODE_DEC_BIT] ? refCurAddr[ch] - 16'd1
                                                   : refCurAddr[ch] + 16'd1;
      refCurCount[ch] = refCurCount[ch] - 16'd1;
    end
  endtask

  // strobe low for four cycles then high for four
  task automatic busWrite(input logic [3:0] a, input logic [7:0] d);
    addr   = a;
    dataIn = d;
    csN    = 1'b0;
    iowN   = 1'b0;
    // register write lands on the third edge
    repeat (3) @(posedge cpuIf);
    #1;
    modelWrite(a, d);
    @(posedge cpuIf);
    #1;
    csN  = 1'b1;
    iowN = 1'b1;
    repeat (4) @(posedge cpuIf);
    #1;
  endtask

  task automatic busRead(input logic [3:0] a, input logic [7:0] expected);
    addr = a;
    csN  = 1'b0;
    iorN = 1'b0;
    repeat (4) @(posedge cpuIf);
    #1;
    checkValue("dataOut", dataOut, expected);
    checkValue("dataOutEn", dataOutEn, 16'd1);
    csN  = 1'b1;
    iorN = 1'b1;
    repeat (4) @(posedge cpuIf);
    #1;
    // pointer toggle and status clear follow rdDone
    if (!a[3])
      refPtr = !refPtr;
    else if (a == 4'b1000)
      refStatus = 4'b0000;
  endtask

  // low byte then high byte with the pointer at low
  task automatic loadWord(input logic [1:0] ch, input logic isCount, input logic [15:0] value);
    busWrite({1'b0, ch, isCount}, value[7:0]);
    busWrite({1'b0, ch, isCount}, value[15:8]);
  endtask

  task automatic readWord(input logic [1:0] ch, input logic isCount, input logic [15:0] value);
    busRead({1'b0, ch, isCount}, value[7:0]);
    busRead({1'b0, ch, isCount}, value[15:8]);
  endtask

  task automatic stepChannel(input logic [1:0] ch, output logic tc);
    xferChannel = ch;
    xferStep    = 1'b1;
    @(posedge cpuIf);
    #1;
    xferStep = 1'b0;
    modelStep(ch);
    tc = tcPulse;
    @(posedge cpuIf);
    #1;
    expectTc = 1'b0;
  endtask

  // continuous compare against the model at the falling edge
  always @(negedge cpuIf)
  begin
    if (!rst)
    begin
      checkValue("xferAddress", xferAddress, refCurAddr[xferChannel]);
      checkValue("xferMode", xferMode, refMode[xferChannel]);
      checkValue("commandReg", commandReg, refCmd);
      checkValue("tcPulse", tcPulse, expectTc);
    end
  end

  always @(posedge cpuIf)
  begin
    cycleCount++;
    if (cycleCount >= cycleLimit)
    begin
      $display("run stopped at the cycle limit of %0d cycles", cycleLimit);
      $display("checks %0d, errors %0d", checkCount, errorCount);
      $display("Errors found");
      $finish;
    end
  end

  initial
  begin
    rst         = 1'b1;
    csN         = 1'b1;
    iorN        = 1'b1;
    iowN        = 1'b1;
    addr        = 4'h0;
    dataIn      = 8'h00;
    xferStep    = 1'b0;
    xferChannel = 2'd0;
    lfsrState   = 8'd85;
    checkCount  = 0;
    errorCount  = 0;
    cycleCount  = 0;
    refCmd      = 8'h00;
    refPtr      = 1'b0;
    refStatus   = 4'b0000;
    expectTc    = 1'b0;
    for (int i = 0; i < `DMA_CHANNELS; i++)
    begin
      refBaseAddr[i]  = 16'h0000;
      refCurAddr[i]   = 16'h0000;
      refBaseCount[i] = 16'h0000;
      refCurCount[i]  = 16'h0000;
      refMode[i]      = 8'h00;
    end
    repeat (16) @(posedge cpuIf);
    #1;
    rst = 1'b0;

    // everything zero out of reset
    checkValue("dataOutEn", dataOutEn, 16'd0);
    checkValue("tcPulse", tcPulse, 16'd0);
    checkValue("commandReg", commandReg, 16'd0);
    for (int ch = 0; ch < `DMA_CHANNELS; ch++)
    begin
      readWord(ch, 1'b0, 16'h0000);
      readWord(ch, 1'b1, 16'h0000);
    end

    // random address and count per channel
    for (int ch = 0; ch < `DMA_CHANNELS; ch++)
    begin
      nextRandom(16, loadedAddr[ch]);
      nextRandom(16, loadedCount[ch]);
      loadWord(ch, 1'b0, loadedAddr[ch]);
      loadWord(ch, 1'b1, loadedCount[ch]);
    end
    for (int ch = 0; ch < `DMA_CHANNELS; ch++)
    begin
      readWord(ch, 1'b0, loadedAddr[ch]);
      readWord(ch, 1'b1, loadedCount[ch]);
    end

    // clear between bytes restarts at the low byte
    busWrite(4'b0010, 8'hA5);
    busWrite(4'b1100, 8'h00);
    nextRandom(16, loadedAddr[1]);
    loadWord(2'd1, 1'b0, loadedAddr[1]);
    readWord(2'd1, 1'b0, loadedAddr[1]);

    nextRandom(8, randWord);
    busWrite(4'b1000, randWord[7:0]);
    checkValue("commandReg", commandReg, {8'h00, randWord[7:0]});

    // channel 1 increments, channel 2 decrements
    busWrite(4'b1011, 8'h01);
    busWrite(4'b1011, 8'h22);
    for (int n = 0; n < 4; n++)
      stepChannel(2'd1, sawTc);
    checkValue("xferAddress", xferAddress, loadedAddr[1] + 16'd4);
    checkValue("xferMode", xferMode, 16'h0001);
    for (int n = 0; n < 4; n++)
      stepChannel(2'd2, sawTc);
    checkValue("xferAddress", xferAddress, loadedAddr[2] - 16'd4);
    checkValue("xferMode", xferMode, 16'h0022);

    // flush any status left by the steps above
    busRead(4'b1000, refByte(4'b1000));

    // count 2 on channel 3 reaches terminal count at the third step
    busWrite(4'b1011, 8'h03);
    loadWord(2'd3, 1'b1, 16'h0002);
    stepChannel(2'd3, sawTc);
    checkValue("tcPulse", sawTc, 16'd0);
    stepChannel(2'd3, sawTc);
    checkValue("tcPulse", sawTc, 16'd0);
    stepChannel(2'd3, sawTc);
    checkValue("tcPulse", sawTc, 16'd1);
    busRead(4'b1000, 8'h08);
    busRead(4'b1000, 8'h00);

    // auto-initialize on channel 0
    busWrite(4'b1011, 8'h10);
    nextRandom(16, loadedAddr[0]);
    loadWord(2'd0, 1'b0, loadedAddr[0]);
    loadWord(2'd0, 1'b1, 16'h0001);
    stepChannel(2'd0, sawTc);
    stepChannel(2'd0, sawTc);
    checkValue("tcPulse", sawTc, 16'd1);
    readWord(2'd0, 1'b0, loadedAddr[0]);
    readWord(2'd0, 1'b1, 16'h0001);
    // no reload on channel 3
    readWord(2'd3, 1'b1, 16'hFFFF);
    readWord(2'd3, 1'b0, loadedAddr[3] + 16'd3);

    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+src
src/dmaPkg.sv
src/dmaBusDecode.sv
src/dmaChannelRegs.sv
src/dmaReadPort.sv
src/dmaDatapath.sv
tb/dmaDatapathTb.sv
